/* desc64_frontend.f */
logic/desc64_pkg.sv
logic/desc64_fifo.sv
logic/desc64_mem_arbiter.sv
logic/desc64_fetch.sv
logic/desc64_complete.sv
logic/desc64_frontend_top.sv
dv/desc64_mem_model.sv
dv/desc64_tb.sv

/* dv/desc64_tb.sv */
`timescale 1ns/10ps

module desc64_tb;

    localparam logic [63:0] DESC_BASE    = 64'h0000_0000_8000_1000;
    localparam logic [63:0] END_OF_CHAIN = 64'hffff_ffff_ffff_ffff;
    localparam logic [63:0] CHAIN_A      = DESC_BASE;
    localparam logic [63:0] CHAIN_B      = DESC_BASE + 64'd96;
    localparam int          RAND_SEED    = 32'h7ce26181;
    // six chain pushes with fifteen descriptors in all, about 250 cycles per descriptor
    localparam int          TIMEOUT_CYCLES = 4000;

    logic        clk;
    logic        arst_n;
    logic        reload;
    logic [63:0] desc_addr;
    logic        desc_valid;
    logic        desc_ready;
    logic        be_valid;
    logic [63:0] be_src;
    logic [63:0] be_dst;
    logic [31:0] be_len;
    logic [7:0]  be_id;
    logic        be_ready = 1'b0;
    logic        be_done = 1'b0;
    logic        mem_req;
    logic        mem_we;
    logic [63:0] mem_addr;
    logic [63:0] mem_wdata;
    logic        mem_ready;
    logic [63:0] mem_rdata;
    logic        irq;
    logic        busy;

    // expected descriptor order, appended as chains are pushed
    int exp_order [32] = '{default: 0};
    int order_len = 0;
    int req_head = 0;
    int cpl_head = 0;
    int done_seen = 0;
    int issued = 0;
    int irq_seen = 0;
    int irq_expected = 0;
    int err_cnt = 0;
    int err_base = 0;
    int test_start = 0;
    int test_cnt = 0;
    int fail_cnt = 0;
    int cycles = 0;
    integer seed = RAND_SEED;

    int          exp_desc;
    int          cpl_desc;
    logic [63:0] exp_src;
    logic [63:0] exp_dst;
    logic [31:0] exp_len;
    logic [7:0]  exp_id;
    logic [63:0] exp_cpl_addr;
    logic        exp_irq;
    logic        be_fire;
    logic        wr_fire;

    desc64_frontend_top UUT (
        .clk_i       (clk),
        .arst_n_i    (arst_n),
        .desc_addr_i (desc_addr),
        .desc_valid_i(desc_valid),
        .desc_ready_o(desc_ready),
        .be_valid_o  (be_valid),
        .be_src_o    (be_src),
        .be_dst_o    (be_dst),
        .be_len_o    (be_len),
        .be_id_o     (be_id),
        .be_ready_i  (be_ready),
        .be_done_i   (be_done),
        .mem_req_o   (mem_req),
        .mem_we_o    (mem_we),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_ready_i (mem_ready),
        .mem_rdata_i (mem_rdata),
        .irq_o       (irq),
        .busy_o      (busy)
    );

    desc64_mem_model #(
        .DESC_BASE(DESC_BASE),
        .SEED     (RAND_SEED)
    ) u_mem (
        .clk_i      (clk),
        .reload_i   (reload),
        .mem_req_i  (mem_req),
        .mem_we_i   (mem_we),
        .mem_addr_i (mem_addr),
        .mem_wdata_i(mem_wdata),
        .mem_ready_o(mem_ready),
        .mem_rdata_o(mem_rdata)
    );

    assign be_fire      = be_valid && be_ready;
    assign wr_fire      = mem_req && mem_we && mem_ready;
    assign exp_desc     = exp_order[req_head];
    assign exp_src      = u_mem.src_tab[exp_desc];
    assign exp_dst      = u_mem.dst_tab[exp_desc];
    assign exp_len      = u_mem.len_tab[exp_desc];
    assign exp_id       = u_mem.id_tab[exp_desc];
    assign cpl_desc     = exp_order[cpl_head];
    assign exp_cpl_addr = DESC_BASE + 64'(cpl_desc) * 64'd32;
    assign exp_irq      = u_mem.irq_tab[cpl_desc];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end else begin
            cycles <= cycles + 1;
        end
    end

    always @(posedge clk) begin
        if (be_fire) begin
            req_head <= req_head + 1;
        end
        if (wr_fire) begin
            cpl_head <= cpl_head + 1;
        end
        if (be_done) begin
            done_seen <= done_seen + 1;
        end
        if (irq) begin
            irq_seen <= irq_seen + 1;
        end
    end

    // backend model with random stalls and one done pulse per accepted request
    always @(negedge clk) begin
        if (!arst_n) begin
            be_ready <= 1'b0;
            be_done  <= 1'b0;
        end else begin
            be_ready <= ($random(seed) & 3) != 0;
            if (issued < req_head && ($random(seed) & 3) == 0) begin
                be_done <= 1'b1;
                issued  <= issued + 1;
            end else begin
                be_done <= 1'b0;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
        err_cnt = err_cnt + 1;
    endtask

    task automatic report_error(input string what);
        $display("error at %0t: %s", $time, what);
        err_cnt = err_cnt + 1;
    endtask

    assert property (@(posedge clk) disable iff (!arst_n) be_fire |-> req_head < order_len)
        else report_error("burst request issued past the end of its chain");
    assert property (@(posedge clk) disable iff (!arst_n) be_fire |-> be_src == exp_src)
        else report_mismatch("be_src_o", $sampled(be_src), $sampled(exp_src));
    assert property (@(posedge clk) disable iff (!arst_n) be_fire |-> be_dst == exp_dst)
        else report_mismatch("be_dst_o", $sampled(be_dst), $sampled(exp_dst));
    assert property (@(posedge clk) disable iff (!arst_n) be_fire |-> be_len == exp_len)
        else report_mismatch("be_len_o", $sampled(be_len), $sampled(exp_len));
    assert property (@(posedge clk) disable iff (!arst_n) be_fire |-> be_id == exp_id)
        else report_mismatch("be_id_o", $sampled(be_id), $sampled(exp_id));

    // stalled requests hold still
    assert property (@(posedge clk) disable iff (!arst_n)
        be_valid && !be_ready |=> be_valid && $stable(be_src) && $stable(be_dst)
            && $stable(be_len) && $stable(be_id))
        else report_error("burst request changed or dropped while stalled");
    assert property (@(posedge clk) disable iff (!arst_n)
        mem_req && !mem_ready |=> mem_req && $stable(mem_addr) && $stable(mem_we))
        else report_error("memory request changed or dropped before mem_ready_i");

    // write-back happens in submission order and only after its done pulse
    assert property (@(posedge clk) disable iff (!arst_n) wr_fire |-> cpl_head < done_seen)
        else report_error("descriptor written back before its done pulse");
    assert property (@(posedge clk) disable iff (!arst_n) wr_fire |-> mem_addr == exp_cpl_addr)
        else report_mismatch("mem_addr_o", $sampled(mem_addr), $sampled(exp_cpl_addr));
    assert property (@(posedge clk) disable iff (!arst_n) wr_fire |-> mem_wdata == END_OF_CHAIN)
        else report_mismatch("mem_wdata_o", $sampled(mem_wdata), END_OF_CHAIN);
    assert property (@(posedge clk) disable iff (!arst_n) wr_fire && exp_irq |=> irq)
        else report_error("no irq pulse after write-back of an irq descriptor");
    assert property (@(posedge clk) disable iff (!arst_n) irq |-> $past(wr_fire && exp_irq))
        else report_error("irq pulse without a matching write-back");

    task automatic push_chain(input logic [63:0] head);
        logic [63:0] addr;
        int          k;
        addr = head;
        while (addr != END_OF_CHAIN) begin
            k = int'((addr - DESC_BASE) >> 5);
            exp_order[order_len] = k;
            order_len = order_len + 1;
            if (u_mem.irq_tab[k]) begin
                irq_expected = irq_expected + 1;
            end
            addr = u_mem.next_tab[k];
        end
        @(negedge clk);
        desc_addr  = head;
        desc_valid = 1'b1;
        while (!desc_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        desc_valid = 1'b0;
    endtask

    task automatic wait_drained();
        @(negedge clk);
        while (cpl_head != order_len || busy) begin
            @(negedge clk);
        end
    endtask

    task automatic reload_memory();
        @(negedge clk);
        reload = 1'b1;
        @(negedge clk);
        reload = 1'b0;
    endtask

    task automatic open_test();
        err_base   = err_cnt;
        test_start = order_len;
    endtask

    task automatic close_test(input string name);
        for (int i = test_start; i < order_len; i++) begin
            assert (u_mem.mem_q[4*exp_order[i]] == END_OF_CHAIN)
                else report_mismatch("mem word 0", u_mem.mem_q[4*exp_order[i]], END_OF_CHAIN);
        end
        assert (req_head == order_len)
            else report_mismatch("burst request count", 64'(req_head), 64'(order_len));
        assert (irq_seen == irq_expected)
            else report_mismatch("irq_o pulse count", 64'(irq_seen), 64'(irq_expected));
        assert (!be_valid) else report_mismatch("be_valid_o", 64'(be_valid), 64'd0);
        assert (!mem_req) else report_mismatch("mem_req_o", 64'(mem_req), 64'd0);
        assert (!irq) else report_mismatch("irq_o", 64'(irq), 64'd0);
        assert (!busy) else report_mismatch("busy_o", 64'(busy), 64'd0);
        test_cnt = test_cnt + 1;
        if (err_cnt == err_base) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_base);
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        reload     = 1'b1;
        desc_addr  = '0;
        desc_valid = 1'b0;
        repeat (4) @(negedge clk);
        arst_n = 1'b1;
        reload = 1'b0;

        open_test();
        @(negedge clk);
        assert (desc_ready) else report_mismatch("desc_ready_o", 64'(desc_ready), 64'd1);
        close_test("reset_state");

        open_test();
        push_chain(CHAIN_A);
        wait_drained();
        close_test("chain_a");

        open_test();
        push_chain(CHAIN_B);
        wait_drained();
        close_test("chain_b");

        // both chains queued back to back
        reload_memory();
        open_test();
        push_chain(CHAIN_A);
        push_chain(CHAIN_B);
        wait_drained();
        close_test("chain_a_then_b");

        reload_memory();
        open_test();
        push_chain(CHAIN_B);
        push_chain(CHAIN_A);
        wait_drained();
        close_test("chain_b_then_a");

        $display("tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* dv/desc64_mem_model.sv */
`timescale 1ns/10ps

module desc64_mem_model #(
    parameter logic [63:0] DESC_BASE = 64'h0000_0000_8000_1000,
    parameter int          SEED      = 1
) (
    input  logic        clk_i,
    input  logic        reload_i,
    input  logic        mem_req_i,
    input  logic        mem_we_i,
    input  logic [63:0] mem_addr_i,
    input  logic [63:0] mem_wdata_i,
    output logic        mem_ready_o,
    output logic [63:0] mem_rdata_o
);

    localparam int          N_DESC       = 5;
    localparam logic [63:0] END_OF_CHAIN = 64'hffff_ffff_ffff_ffff;

    // descriptor table holding chain a in entries 0..2 and chain b in 3..4
    logic [63:0] src_tab  [N_DESC];
    logic [63:0] dst_tab  [N_DESC];
    logic [31:0] len_tab  [N_DESC];
    logic [7:0]  id_tab   [N_DESC];
    logic        irq_tab  [N_DESC];
    logic [63:0] next_tab [N_DESC];

    logic [63:0] mem_q [N_DESC*4];
    logic [63:0] offset;
    logic        in_range;
    logic        ready_q = 1'b0;
    integer      seed;

    initial begin
        seed = SEED;
        for (int k = 0; k < N_DESC; k++) begin
            src_tab[k]  = 64'h0000_0010_0000_0000 + 64'(k) * 64'h1000;
            dst_tab[k]  = 64'h0000_0020_0000_0040 + 64'(k) * 64'h2000;
            len_tab[k]  = 32'h0000_0104 + 32'(k) * 32'h100;
            id_tab[k]   = 8'h30 + 8'(k);
            irq_tab[k]  = (k != 1) && (k != 4);
            next_tab[k] = (k == 2 || k == 4) ? END_OF_CHAIN : DESC_BASE + 64'(k + 1) * 64'd32;
        end
    end

    assign offset      = mem_addr_i - DESC_BASE;
    assign in_range    = mem_addr_i >= DESC_BASE && mem_addr_i < DESC_BASE + 64'(N_DESC * 32);
    // outside the table every address reads back its own pattern
    assign mem_rdata_o = in_range ? mem_q[offset[7:3]] : {mem_addr_i[31:0], ~mem_addr_i[63:32]};
    assign mem_ready_o = ready_q;

    // random wait states while a request is open
    always @(negedge clk_i) begin
        ready_q <= mem_req_i && (($random(seed) & 1) == 1);
    end

    always @(posedge clk_i) begin
        if (reload_i) begin
            for (int k = 0; k < N_DESC; k++) begin
                // bit 8 sits in a flag field the frontend ignores
                mem_q[4*k]     <= {8'h00, id_tab[k], 8'h01, 7'h00, irq_tab[k], len_tab[k]};
                mem_q[4*k + 1] <= next_tab[k];
                mem_q[4*k + 2] <= src_tab[k];
                mem_q[4*k + 3] <= dst_tab[k];
            end
        end else if (mem_req_i && mem_we_i && ready_q && in_range) begin
            mem_q[offset[7:3]] <= mem_wdata_i;
        end
    end

endmodule

/* logic/desc64_frontend_top.sv */
`timescale 1ns/10ps

module desc64_frontend_top (
    input  logic                            clk_i,
    input  logic                            arst_n_i,
    input  logic [desc64_pkg::ADDR_W-1:0]   desc_addr_i,
    input  logic                            desc_valid_i,
    output logic                            desc_ready_o,
    output logic                            be_valid_o,
    output logic [desc64_pkg::ADDR_W-1:0]   be_src_o,
    output logic [desc64_pkg::ADDR_W-1:0]   be_dst_o,
    output logic [desc64_pkg::ADDR_W/2-1:0] be_len_o,
    output logic [desc64_pkg::ID_W-1:0]     be_id_o,
    input  logic                            be_ready_i,
    input  logic                            be_done_i,
    output logic                            mem_req_o,
    output logic                            mem_we_o,
    output logic [desc64_pkg::ADDR_W-1:0]   mem_addr_o,
    output logic [desc64_pkg::ADDR_W-1:0]   mem_wdata_o,
    input  logic                            mem_ready_i,
    input  logic [desc64_pkg::ADDR_W-1:0]   mem_rdata_i,
    output logic                            irq_o,
    output logic                            busy_o
);

    import desc64_pkg::*;

    // address queue to fetch stage
    logic [ADDR_W-1:0] aq_data;
    logic              aq_valid;
    logic              aq_ready;
    logic              aq_empty;

    // fetch stage to pending queue to completion stage
    logic [ADDR_W-1:0] push_addr;
    logic              push_irq;
    logic              push_valid;
    logic              push_ready;
    logic [ADDR_W:0]   pq_data;
    logic              pq_valid;
    logic              pq_ready;
    logic              pq_empty;

    // stage memory requests
    logic              fetch_mem_valid;
    logic [ADDR_W-1:0] fetch_mem_addr;
    logic              fetch_mem_ready;
    logic [ADDR_W-1:0] fetch_mem_rdata;
    logic              cpl_mem_valid;
    logic [ADDR_W-1:0] cpl_mem_addr;
    logic [ADDR_W-1:0] cpl_mem_wdata;
    logic              cpl_mem_ready;

    logic              fetch_idle;
    logic              cpl_idle;

    desc64_fifo #(
        .WIDTH(ADDR_W),
        .DEPTH(ADDR_FIFO_DEPTH)
    ) u_addr_fifo (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_data_i  (desc_addr_i),
        .in_valid_i (desc_valid_i),
        .in_ready_o (desc_ready_o),
        .out_data_o (aq_data),
        .out_valid_o(aq_valid),
        .out_ready_i(aq_ready),
        .empty_o    (aq_empty)
    );

    desc64_fetch u_fetch (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .addr_i      (aq_data),
        .addr_valid_i(aq_valid),
        .addr_ready_o(aq_ready),
        .mem_valid_o (fetch_mem_valid),
        .mem_addr_o  (fetch_mem_addr),
        .mem_ready_i (fetch_mem_ready),
        .mem_rdata_i (fetch_mem_rdata),
        .be_valid_o  (be_valid_o),
        .be_src_o    (be_src_o),
        .be_dst_o    (be_dst_o),
        .be_len_o    (be_len_o),
        .be_id_o     (be_id_o),
        .be_ready_i  (be_ready_i),
        .pend_addr_o (push_addr),
        .pend_irq_o  (push_irq),
        .pend_valid_o(push_valid),
        .pend_ready_i(push_ready),
        .idle_o      (fetch_idle)
    );

    // irq flag rides in the top bit
    desc64_fifo #(
        .WIDTH(ADDR_W + 1),
        .DEPTH(PENDING_FIFO_DEPTH)
    ) u_pending_fifo (
        .clk_i      (clk_i),
        .arst_n_i   (arst_n_i),
        .in_data_i  ({push_irq, push_addr}),
        .in_valid_i (push_valid),
        .in_ready_o (push_ready),
        .out_data_o (pq_data),
        .out_valid_o(pq_valid),
        .out_ready_i(pq_ready),
        .empty_o    (pq_empty)
    );

    desc64_complete u_complete (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .pend_addr_i (pq_data[ADDR_W-1:0]),
        .pend_irq_i  (pq_data[ADDR_W]),
        .pend_valid_i(pq_valid),
        .pend_ready_o(pq_ready),
        .done_i      (be_done_i),
        .mem_valid_o (cpl_mem_valid),
        .mem_addr_o  (cpl_mem_addr),
        .mem_wdata_o (cpl_mem_wdata),
        .mem_ready_i (cpl_mem_ready),
        .irq_o       (irq_o),
        .idle_o      (cpl_idle)
    );

    desc64_mem_arbiter u_mem_arbiter (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .fetch_valid_i(fetch_mem_valid),
        .fetch_addr_i (fetch_mem_addr),
        .fetch_ready_o(fetch_mem_ready),
        .fetch_rdata_o(fetch_mem_rdata),
        .cpl_valid_i  (cpl_mem_valid),
        .cpl_addr_i   (cpl_mem_addr),
        .cpl_wdata_i  (cpl_mem_wdata),
        .cpl_ready_o  (cpl_mem_ready),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ready_i  (mem_ready_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    assign busy_o = !fetch_idle || !cpl_idle || !aq_empty || !pq_empty;

endmodule

/* logic/desc64_complete.sv */
`timescale 1ns/10ps

module desc64_complete (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic [desc64_pkg::ADDR_W-1:0] pend_addr_i,
    input  logic                          pend_irq_i,
    input  logic                          pend_valid_i,
    output logic                          pend_ready_o,
    input  logic                          done_i,
    output logic                          mem_valid_o,
    output logic [desc64_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [desc64_pkg::ADDR_W-1:0] mem_wdata_o,
    input  logic                          mem_ready_i,
    output logic                          irq_o,
    output logic                          idle_o
);

    import desc64_pkg::*;

    complete_state_e     state_q;
    logic [DONE_CNT_W-1:0] done_cnt_q;
    logic                cnt_dec;
    logic [ADDR_W-1:0]   addr_q;
    logic                irq_q;

    assign pend_ready_o = state_q == CPL_IDLE;
    assign idle_o       = state_q == CPL_IDLE;
    assign mem_valid_o  = state_q == CPL_WRITE;
    assign mem_addr_o   = addr_q;
    // all ones over flags and length marks the descriptor as done
    assign mem_wdata_o  = {ADDR_W{1'b1}};
    assign irq_o        = state_q == CPL_IRQ;

    assign cnt_dec = (state_q == CPL_WAIT) && (done_cnt_q != '0);

    // done pulses may arrive before their descriptor reaches this stage
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            done_cnt_q <= '0;
        end else begin
            done_cnt_q <= done_cnt_q + DONE_CNT_W'(done_i) - DONE_CNT_W'(cnt_dec);
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= CPL_IDLE;
        end else begin
            case (state_q)
                CPL_IDLE: begin
                    if (pend_valid_i) begin
                        state_q <= CPL_WAIT;
                    end
                end
                CPL_WAIT: begin
                    if (cnt_dec) begin
                        state_q <= CPL_WRITE;
                    end
                end
                CPL_WRITE: begin
                    if (mem_ready_i) begin
                        state_q <= irq_q ? CPL_IRQ : CPL_IDLE;
                    end
                end
                CPL_IRQ: begin
                    state_q <= CPL_IDLE;
                end
                default: begin
                    state_q <= CPL_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (pend_ready_o && pend_valid_i) begin
            addr_q <= pend_addr_i;
            irq_q  <= pend_irq_i;
        end
    end

    // a full counter must not take another completion without draining one
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !(done_cnt_q == {DONE_CNT_W{1'b1}} && done_i && !cnt_dec));

endmodule

/* logic/desc64_fetch.sv */
`timescale 1ns/10ps

module desc64_fetch (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic [desc64_pkg::ADDR_W-1:0]       addr_i,
    input  logic                                addr_valid_i,
    output logic                                addr_ready_o,
    output logic                                mem_valid_o,
    output logic [desc64_pkg::ADDR_W-1:0]       mem_addr_o,
    input  logic                                mem_ready_i,
    input  logic [desc64_pkg::ADDR_W-1:0]       mem_rdata_i,
    output logic                                be_valid_o,
    output logic [desc64_pkg::ADDR_W-1:0]       be_src_o,
    output logic [desc64_pkg::ADDR_W-1:0]       be_dst_o,
    output logic [desc64_pkg::ADDR_W/2-1:0]     be_len_o,
    output logic [desc64_pkg::ID_W-1:0]         be_id_o,
    input  logic                                be_ready_i,
    output logic [desc64_pkg::ADDR_W-1:0]       pend_addr_o,
    output logic                                pend_irq_o,
    output logic                                pend_valid_o,
    input  logic                                pend_ready_i,
    output logic                                idle_o
);

    import desc64_pkg::*;

    fetch_state_e      state_q;
    logic [1:0]        word_cnt_q;
    logic              be_valid_q;
    logic              pend_valid_q;
    logic [ADDR_W-1:0] base_q;
    logic [ADDR_W-1:0] next_q;
    logic [ADDR_W-1:0] src_q;
    logic [ADDR_W-1:0] dst_q;
    logic [ADDR_W/2-1:0] len_q;
    logic [ID_W-1:0]   id_q;
    logic              irq_q;
    logic              last_word;
    logic              submit_done;

    assign addr_ready_o = state_q == FETCH_IDLE;
    assign idle_o       = state_q == FETCH_IDLE;
    assign mem_valid_o  = state_q == FETCH_READ;
    assign mem_addr_o   = base_q + ADDR_W'(word_cnt_q) * WORD_BYTES;
    assign last_word    = word_cnt_q == 2'(DESC_WORDS - 1);

    // both handshakes may land in any order, each flag only waits on its own ready
    assign submit_done = (!be_valid_q || be_ready_i) && (!pend_valid_q || pend_ready_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q      <= FETCH_IDLE;
            word_cnt_q   <= '0;
            be_valid_q   <= 1'b0;
            pend_valid_q <= 1'b0;
        end else begin
            case (state_q)
                FETCH_IDLE: begin
                    if (addr_valid_i) begin
                        word_cnt_q <= '0;
                        state_q    <= FETCH_READ;
                    end
                end
                FETCH_READ: begin
                    if (mem_ready_i) begin
                        word_cnt_q <= word_cnt_q + 1'b1;
                        if (last_word) begin
                            be_valid_q   <= 1'b1;
                            pend_valid_q <= 1'b1;
                            state_q      <= FETCH_SUBMIT;
                        end
                    end
                end
                FETCH_SUBMIT: begin
                    if (be_ready_i) begin
                        be_valid_q <= 1'b0;
                    end
                    if (pend_ready_i) begin
                        pend_valid_q <= 1'b0;
                    end
                    if (submit_done) begin
                        word_cnt_q <= '0;
                        state_q    <= (next_q == ADDR_SENTINEL) ? FETCH_IDLE : FETCH_READ;
                    end
                end
                default: begin
                    state_q <= FETCH_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (addr_ready_o && addr_valid_i) begin
            base_q <= addr_i;
        end else if (state_q == FETCH_SUBMIT && submit_done) begin
            // walk the chain
            base_q <= next_q;
        end
        if (mem_valid_o && mem_ready_i) begin
            case (word_cnt_q)
                2'd0: begin
                    len_q <= mem_rdata_i[ADDR_W/2-1:0];
                    id_q  <= mem_rdata_i[ADDR_W/2 + ID_LSB +: ID_W];
                    irq_q <= mem_rdata_i[ADDR_W/2 + FLAG_IRQ_BIT];
                end
                2'd1: next_q <= mem_rdata_i;
                2'd2: src_q  <= mem_rdata_i;
                default: dst_q <= mem_rdata_i;
            endcase
        end
    end

    assign be_valid_o   = be_valid_q;
    assign be_src_o     = src_q;
    assign be_dst_o     = dst_q;
    assign be_len_o     = len_q;
    assign be_id_o      = id_q;
    assign pend_valid_o = pend_valid_q;
    assign pend_addr_o  = base_q;
    assign pend_irq_o   = irq_q;

    // a stalled burst request holds its payload until the backend takes it
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        be_valid_o && !be_ready_i |=>
            be_valid_o && $stable(be_src_o) && $stable(be_dst_o)
            && $stable(be_len_o) && $stable(be_id_o));

endmodule

/* logic/desc64_mem_arbiter.sv */
`timescale 1ns/10ps

module desc64_mem_arbiter (
    input  logic                          clk_i,
    input  logic                          arst_n_i,
    input  logic                          fetch_valid_i,
    input  logic [desc64_pkg::ADDR_W-1:0] fetch_addr_i,
    output logic                          fetch_ready_o,
    output logic [desc64_pkg::ADDR_W-1:0] fetch_rdata_o,
    input  logic                          cpl_valid_i,
    input  logic [desc64_pkg::ADDR_W-1:0] cpl_addr_i,
    input  logic [desc64_pkg::ADDR_W-1:0] cpl_wdata_i,
    output logic                          cpl_ready_o,
    output logic                          mem_req_o,
    output logic                          mem_we_o,
    output logic [desc64_pkg::ADDR_W-1:0] mem_addr_o,
    output logic [desc64_pkg::ADDR_W-1:0] mem_wdata_o,
    input  logic                          mem_ready_i,
    input  logic [desc64_pkg::ADDR_W-1:0] mem_rdata_i
);

    import desc64_pkg::*;

    logic locked_q;
    logic grant_cpl_q;
    logic grant_cpl;

    // completion wins on a free port, an open access keeps its owner
    assign grant_cpl = locked_q ? grant_cpl_q : cpl_valid_i;

    assign mem_req_o     = grant_cpl ? cpl_valid_i : fetch_valid_i;
    assign mem_we_o      = grant_cpl;
    assign mem_addr_o    = grant_cpl ? cpl_addr_i : fetch_addr_i;
    assign mem_wdata_o   = grant_cpl ? cpl_wdata_i : '0;
    assign fetch_ready_o = !grant_cpl && mem_ready_i;
    assign cpl_ready_o   = grant_cpl && mem_ready_i;
    assign fetch_rdata_o = grant_cpl ? {ADDR_W{1'b0}} : mem_rdata_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            locked_q    <= 1'b0;
            grant_cpl_q <= 1'b0;
        end else if (mem_req_o) begin
            locked_q    <= !mem_ready_i;
            grant_cpl_q <= grant_cpl;
        end
    end

    // an open access keeps its owner and its address until mem_ready_i
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        mem_req_o && !mem_ready_i |=>
            mem_req_o && $stable(grant_cpl) && $stable(mem_addr_o));

endmodule

/* logic/desc64_fifo.sv */
`timescale 1ns/10ps

module desc64_fifo #(
    parameter int unsigned WIDTH = 64,
    parameter int unsigned DEPTH = 8
) (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic [WIDTH-1:0] in_data_i,
    input  logic             in_valid_i,
    output logic             in_ready_o,
    output logic [WIDTH-1:0] out_data_o,
    output logic             out_valid_o,
    input  logic             out_ready_i,
    output logic             empty_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             push;
    logic             pop;

    assign in_ready_o  = count_q != CNT_W'(DEPTH);
    assign out_valid_o = count_q != '0;
    assign empty_o     = count_q == '0;
    // head word is visible without a read cycle
    assign out_data_o  = mem_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem_q[wr_ptr_q] <= in_data_i;
        end
    end

    // a push never lands on the unread head
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push && !empty_o |-> wr_ptr_q != rd_ptr_q);

    // a stalled head word holds until it is popped
    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o));

endmodule

/* logic/desc64_pkg.sv */
package desc64_pkg;

    // memory port and descriptor word width
    localparam int unsigned ADDR_W = 64;

    // next pointer that terminates a chain
    localparam logic [ADDR_W-1:0] ADDR_SENTINEL = {ADDR_W{1'b1}};

    // descriptor layout in memory
    // word 0 is {flags, length}, word 1 next, word 2 src, word 3 dst
    localparam int unsigned DESC_WORDS = 4;
    localparam int unsigned WORD_BYTES = 8;

    // fields inside the flags half of word 0
    localparam int unsigned FLAG_IRQ_BIT = 0;
    localparam int unsigned ID_LSB       = 16;
    localparam int unsigned ID_W         = 8;

    // queue sizes
    localparam int unsigned ADDR_FIFO_DEPTH    = 8;
    localparam int unsigned PENDING_FIFO_DEPTH = 8;

    // backend completions not yet matched to a pending descriptor
    localparam int unsigned DONE_CNT_W = 5;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_READ,
        FETCH_SUBMIT
    } fetch_state_e;

    typedef enum logic [1:0] {
        CPL_IDLE,
        CPL_WAIT,
        CPL_WRITE,
        CPL_IRQ
    } complete_state_e;

endpackage
